// ==== include/radio_ctrl_params.svh ====
// Build-time constants for the radio control slice
// Include in any module that needs the hold-off, SPI divider or register map
`ifndef RADIO_CTRL_PARAMS_SVH
`define RADIO_CTRL_PARAMS_SVH

//////////////////////////////////////////////////
// Clock hold-off after PLL lock
//////////////////////////////////////////////////
// Ready after counter reaches all-ones
`define RC_HOLDOFF_BITS 4      // Short for simulation, widen for the board

//////////////////////////////////////////////////
// SPI master timing
//////////////////////////////////////////////////
`define RC_SPI_DIV 2           // bus_clk cycles per sclk half period

//////////////////////////////////////////////////
// Settings register map, 7-bit addresses
//////////////////////////////////////////////////
`define RC_ADDR_ATR1 7'd1      // Front-end ATR lines, chain 1
`define RC_ADDR_ATR2 7'd2      // Front-end ATR lines, chain 2
`define RC_ADDR_MISC 7'd3      // Band selects, codec reset, mimo, ref select

`endif

// ==== src/radio_ctrl_pkg.sv ====
// Shared types of the radio control path
// Command word layout seen by intake, decode and the testbench
`default_nettype none

package radio_ctrl_pkg;

   // Bit 31 of every command word
   typedef enum logic {
      REG_WRITE = 1'b0,
      SPI_XFER  = 1'b1
   } cmd_kind_e;

   // SPI target, codes 2 and 3 select nothing
   typedef enum logic [1:0] {
      SLV_CAT = 2'd0,   // RF transceiver
      SLV_PLL = 2'd1    // Reference PLL
   } spi_slave_e;

   // Register write view
   typedef struct packed {
      cmd_kind_e   kind;
      logic [6:0]  addr;
      logic [23:0] data;   // Only low byte stored
   } reg_view_t;

   // SPI job view
   typedef struct packed {
      cmd_kind_e   kind;
      spi_slave_e  slave;
      logic [4:0]  len;    // Bit count, 0 means 24
      logic [23:0] data;   // Sent MSB first
   } spi_view_t;

   // One 32-bit word, decoded by its kind bit
   typedef union packed {
      reg_view_t regw;
      spi_view_t spi;
   } cmd_word_u;

endpackage

`default_nettype wire

// ==== src/clocks_ready_hold.sv ====
// Holds the bus domain in reset until the PLL has been locked for a while
// Produces the synchronized bus reset and the ready flag for the command path
`timescale 1ns/1ps
`default_nettype none
`include "radio_ctrl_params.svh"

module clocks_ready_hold (
   input  logic bus_clk,
   input  logic reset_global,
   input  logic locked,
   output logic bus_rst,
   output logic clocks_ready
);

   logic [`RC_HOLDOFF_BITS-1:0] holdoff_cnt;  // Cycles since lock
   logic                        ready_raw;    // Hold-off done, before sync
   logic [1:0]                  rst_sync;     // Release pipe for bus_rst

   //////////////////////////////////////////////////
   // Hold-off counter
   //////////////////////////////////////////////////
   // Loss of lock restarts the count at once
   always_ff @(posedge bus_clk or posedge reset_global or negedge locked) begin
      if (reset_global || !locked) begin
         holdoff_cnt <= '0;
         ready_raw   <= 1'b0;
      end else if (!ready_raw) begin
         holdoff_cnt <= holdoff_cnt + 1'b1;
         ready_raw   <= (holdoff_cnt == '1);   // Sticks once set
      end
   end

   //////////////////////////////////////////////////
   // Reset synchronizer
   //////////////////////////////////////////////////
   // Asserts asynchronously, releases two edges after ready_raw
   always_ff @(posedge bus_clk or posedge reset_global or negedge locked) begin
      if (reset_global || !locked) begin
         rst_sync <= 2'b11;
      end else begin
         rst_sync <= {rst_sync[0], ~ready_raw};
      end
   end

   assign bus_rst      = rst_sync[1];
   assign clocks_ready = ~rst_sync[1];   // Same edge as reset release

endmodule

`default_nettype wire

// ==== src/cmd_intake.sv ====
// First pipeline stage, takes host command words under four-phase req/ack
// Holds one word and offers it to decode on its own handshake
`timescale 1ns/1ps
`default_nettype none

module cmd_intake (
   input  logic                      bus_clk,
   input  logic                      bus_rst,
   input  logic                      clocks_ready,
   input  logic                      cmd_req,
   input  radio_ctrl_pkg::cmd_word_u cmd_word,
   output logic                      cmd_ack,
   output logic                      dec_req,
   output radio_ctrl_pkg::cmd_word_u dec_word,
   input  logic                      dec_ack
);
   import radio_ctrl_pkg::*;

   // Decode-side handshake states
   localparam logic [1:0] D_IDLE = 2'd0;   // Nothing offered
   localparam logic [1:0] D_REQ  = 2'd1;   // req high, waiting ack
   localparam logic [1:0] D_DROP = 2'd2;   // req low, waiting ack low

   cmd_word_u  hold_word;   // One-entry holding register
   logic       full;        // hold_word owned by decode handshake
   logic [1:0] dec_st;
   logic       take;        // Host word accepted this edge

   // cmd_ack doubles as the host FSM state
   assign take = !cmd_ack && cmd_req && clocks_ready && !full;

   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         cmd_ack <= 1'b0;
         full    <= 1'b0;
         dec_req <= 1'b0;
         dec_st  <= D_IDLE;
      end else begin
         // Host side
         if (take) begin
            cmd_ack <= 1'b1;
            full    <= 1'b1;
         end else if (cmd_ack && !cmd_req) begin
            cmd_ack <= 1'b0;                      // Host finished phase 3
         end

         // Decode side
         case (dec_st)
            D_IDLE: if (full) begin
               dec_req <= 1'b1;
               dec_st  <= D_REQ;
            end
            D_REQ: if (dec_ack) begin
               dec_req <= 1'b0;
               dec_st  <= D_DROP;
            end
            D_DROP: if (!dec_ack) begin
               full   <= 1'b0;                    // Slot free again
               dec_st <= D_IDLE;
            end
            default: dec_st <= D_IDLE;
         endcase
      end
   end

   // Word stays put until the decode handshake fully closes
   always_ff @(posedge bus_clk) begin
      if (take) hold_word <= cmd_word;
   end

   assign dec_word = hold_word;

   // Host ack must answer a live request, req seen on the edge that raised ack
   a_ack_follows_req : assert property (
      @(posedge bus_clk) disable iff (bus_rst) $rose(cmd_ack) |-> $past(cmd_req)
   ) else $error("cmd_ack rose without cmd_req");

endmodule

`default_nettype wire

// ==== src/settings_decode.sv ====
// Second pipeline stage, splits command words into register writes and SPI jobs
// Owns the ATR and misc output registers and hands SPI jobs to the engine
`timescale 1ns/1ps
`default_nettype none
`include "radio_ctrl_params.svh"

module settings_decode (
   input  logic                       bus_clk,
   input  logic                       bus_rst,
   input  logic                       dec_req,
   input  radio_ctrl_pkg::cmd_word_u  dec_word,
   output logic                       dec_ack,
   output logic                       spi_req,
   output radio_ctrl_pkg::spi_slave_e spi_slave,
   output logic [4:0]                 spi_len,
   output logic [23:0]                spi_data,
   input  logic                       spi_ack,
   output logic [7:0]                 fe_atr1,
   output logic [7:0]                 fe_atr2,
   output logic [7:0]                 misc_outs
);
   import radio_ctrl_pkg::*;

   logic        take;        // Word accepted this edge
   logic        is_spi;      // Kind bit read through the union
   logic [4:0]  len_clip;    // 1 to 24
   logic [23:0] data_mask;   // Keeps the top len_clip bits
   logic        wr_pend;     // Register write lands next edge
   logic [6:0]  wr_addr;
   logic [7:0]  wr_data;
   logic [7:0]  misc_reg;    // Settings copy, before output flop

   assign is_spi = (dec_word.spi.kind == SPI_XFER);

   // Only accept when the engine link is fully idle, keeps write order
   assign take = dec_req && !dec_ack && !spi_req && !spi_ack;

   //////////////////////////////////////////////////
   // SPI length clip and alignment
   //////////////////////////////////////////////////
   always_comb begin
      if (dec_word.spi.len == 5'd0 || dec_word.spi.len > 5'd24) begin
         len_clip = 5'd24;                         // Zero means full word
      end else begin
         len_clip = dec_word.spi.len;
      end
      data_mask = ~(24'hffffff >> len_clip);
   end

   //////////////////////////////////////////////////
   // Handshakes and settings registers
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         dec_ack   <= 1'b0;
         spi_req   <= 1'b0;
         wr_pend   <= 1'b0;
         fe_atr1   <= 8'h00;
         fe_atr2   <= 8'h00;
         misc_reg  <= 8'h00;
         misc_outs <= 8'h00;
      end else begin
         wr_pend <= take && (dec_word.regw.kind == REG_WRITE);

         if (take) dec_ack <= 1'b1;
         else if (!dec_req) dec_ack <= 1'b0;       // Intake dropped req

         if (take && is_spi) spi_req <= 1'b1;
         else if (spi_ack) spi_req <= 1'b0;        // Engine has the job

         if (wr_pend) begin
            case (wr_addr)
               `RC_ADDR_ATR1: fe_atr1  <= wr_data;
               `RC_ADDR_ATR2: fe_atr2  <= wr_data;
               `RC_ADDR_MISC: misc_reg <= wr_data;
               default: ;                          // Unknown address ignored
            endcase
         end
         misc_outs <= misc_reg;                    // Extra flop toward the pins
      end
   end

   // Job and write payload, stable while spi_req is high
   always_ff @(posedge bus_clk) begin
      if (take) begin
         wr_addr   <= dec_word.regw.addr;
         wr_data   <= dec_word.regw.data[7:0];
         spi_slave <= dec_word.spi.slave;
         spi_len   <= len_clip;
         spi_data  <= dec_word.spi.data & data_mask;
      end
   end

endmodule

`default_nettype wire

// ==== src/spi_engine.sv ====
// Third pipeline stage, SPI master for the transceiver and the reference PLL
// Shifts a job MSB first with sclk idle low and returns the captured miso bits
`timescale 1ns/1ps
`default_nettype none
`include "radio_ctrl_params.svh"

module spi_engine (
   input  logic                       bus_clk,
   input  logic                       bus_rst,
   input  logic                       spi_req,
   input  radio_ctrl_pkg::spi_slave_e spi_slave,
   input  logic [4:0]                 spi_len,
   input  logic [23:0]                spi_data,
   output logic                       spi_ack,
   output logic [1:0]                 sen,       // Active low, bit 0 cat
   output logic                       sclk,
   output logic                       mosi,
   input  logic                       miso,
   output logic [23:0]                rb_data,
   output logic                       rb_valid
);
   import radio_ctrl_pkg::*;

   localparam int unsigned DIV_W = $clog2(`RC_SPI_DIV) + 1;
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`RC_SPI_DIV - 1);

   localparam logic [2:0] E_IDLE  = 3'd0;
   localparam logic [2:0] E_SETUP = 3'd1;   // sen low, sclk low
   localparam logic [2:0] E_SHIFT = 3'd2;
   localparam logic [2:0] E_HOLD  = 3'd3;   // Last fall to sen high
   localparam logic [2:0] E_DONE  = 3'd4;

   logic [2:0]       state;
   logic [DIV_W-1:0] div_cnt;
   logic             tick;       // Half period elapsed
   logic             phase;      // Internal sclk, runs even with no select
   logic             accept;
   logic             rise;
   logic             fall;
   logic [23:0]      tx_shift;
   logic [23:0]      rx_shift;
   logic [4:0]       bits_left;
   spi_slave_e       slave_r;
   logic             sel_any;    // Job targets a real slave

   assign tick    = (div_cnt == DIV_LAST);
   assign accept  = (state == E_IDLE) && spi_req && !spi_ack;
   assign rise    = (state == E_SHIFT) && tick && !phase;
   assign fall    = (state == E_SHIFT) && tick && phase;
   assign sel_any = (slave_r == SLV_CAT) || (slave_r == SLV_PLL);

   //////////////////////////////////////////////////
   // Control FSM and pins
   //////////////////////////////////////////////////
   always_ff @(posedge bus_clk or posedge bus_rst) begin
      if (bus_rst) begin
         state    <= E_IDLE;
         div_cnt  <= '0;
         phase    <= 1'b0;
         sclk     <= 1'b0;
         sen      <= 2'b11;
         mosi     <= 1'b0;
         spi_ack  <= 1'b0;
         rb_valid <= 1'b0;
         rb_data  <= 24'h0;
      end else begin
         rb_valid <= 1'b0;
         if (spi_ack && !spi_req) spi_ack <= 1'b0;       // Decode closed link
         if (state == E_IDLE || tick) div_cnt <= '0;
         else div_cnt <= div_cnt + 1'b1;

         case (state)
            E_IDLE: if (accept) begin
               spi_ack <= 1'b1;
               mosi    <= spi_data[23];                  // First bit ahead of sclk
               state   <= E_SETUP;
               case (spi_slave)
                  SLV_CAT: sen <= 2'b10;
                  SLV_PLL: sen <= 2'b01;
                  default: sen <= 2'b11;                 // Dummy job, no select
               endcase
            end
            E_SETUP: if (tick) state <= E_SHIFT;
            E_SHIFT: begin
               if (rise) begin
                  phase <= 1'b1;
                  sclk  <= sel_any;
               end else if (fall) begin
                  phase <= 1'b0;
                  sclk  <= 1'b0;
                  if (bits_left == 5'd1) begin
                     mosi  <= 1'b0;
                     state <= E_HOLD;
                  end else begin
                     mosi <= tx_shift[22];               // Change on falling edge
                  end
               end
            end
            E_HOLD: if (tick) begin
               sen   <= 2'b11;
               state <= E_DONE;
            end
            E_DONE: begin
               rb_data  <= rx_shift;
               rb_valid <= 1'b1;                         // After sen release
               state    <= E_IDLE;
            end
            default: state <= E_IDLE;
         endcase
      end
   end

   // Shift registers and job fields
   always_ff @(posedge bus_clk) begin
      if (accept) begin
         tx_shift  <= spi_data;
         rx_shift  <= 24'h0;                             // Zero-extend readback
         bits_left <= spi_len;
         slave_r   <= spi_slave;
      end else if (rise) begin
         rx_shift <= {rx_shift[22:0], miso};             // Sample on rising edge
      end else if (fall) begin
         tx_shift  <= {tx_shift[22:0], 1'b0};
         bits_left <= bits_left - 1'b1;
      end
   end

   a_one_select : assert property (
      @(posedge bus_clk) disable iff (bus_rst) $onehot0(~sen)
   ) else $error("more than one SPI select active");

   a_sclk_quiet : assert property (
      @(posedge bus_clk) disable iff (bus_rst) (&sen) |-> !sclk
   ) else $error("sclk toggling with no select");

endmodule

`default_nettype wire

// ==== src/radio_ctrl_top.sv ====
// Top of the radio control slice, command pipeline from host port to SPI pins
// Each slave sees sclk and mosi only while its own select is low
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_top (
   input  logic                      bus_clk,
   input  logic                      reset_global,
   input  logic                      locked,
   // Host command port
   input  logic                      cmd_req,
   input  radio_ctrl_pkg::cmd_word_u cmd_word,
   output logic                      cmd_ack,
   // Transceiver SPI
   output logic                      cat_ce,
   output logic                      cat_mosi,
   output logic                      cat_sclk,
   input  logic                      cat_miso,
   // Reference PLL SPI, write only
   output logic                      pll_ce,
   output logic                      pll_mosi,
   output logic                      pll_sclk,
   // Front end and misc controls
   output logic [7:0]                fe_atr1,
   output logic [7:0]                fe_atr2,
   output logic [7:0]                misc_outs,
   // SPI readback
   output logic [23:0]               rb_data,
   output logic                      rb_valid
);
   import radio_ctrl_pkg::*;

   logic        bus_rst;
   logic        clocks_ready;
   logic        dec_req;
   logic        dec_ack;
   cmd_word_u   dec_word;
   logic        spi_req;
   logic        spi_ack;
   spi_slave_e  spi_slave;
   logic [4:0]  spi_len;
   logic [23:0] spi_data;
   logic [1:0]  sen;
   logic        sclk;
   logic        mosi;

   //////////////////////////////////////////////////
   // Reset and hold-off
   //////////////////////////////////////////////////
   clocks_ready_hold clocks_ready_hold_i (
      .bus_clk(bus_clk), .reset_global(reset_global), .locked(locked),
      .bus_rst(bus_rst), .clocks_ready(clocks_ready)
   );

   //////////////////////////////////////////////////
   // Command pipeline
   //////////////////////////////////////////////////
   cmd_intake cmd_intake_i (
      .bus_clk(bus_clk), .bus_rst(bus_rst), .clocks_ready(clocks_ready),
      .cmd_req(cmd_req), .cmd_word(cmd_word), .cmd_ack(cmd_ack),
      .dec_req(dec_req), .dec_word(dec_word), .dec_ack(dec_ack)
   );

   settings_decode settings_decode_i (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .dec_req(dec_req), .dec_word(dec_word), .dec_ack(dec_ack),
      .spi_req(spi_req), .spi_slave(spi_slave), .spi_len(spi_len),
      .spi_data(spi_data), .spi_ack(spi_ack),
      .fe_atr1(fe_atr1), .fe_atr2(fe_atr2), .misc_outs(misc_outs)
   );

   spi_engine spi_engine_i (
      .bus_clk(bus_clk), .bus_rst(bus_rst),
      .spi_req(spi_req), .spi_slave(spi_slave), .spi_len(spi_len),
      .spi_data(spi_data), .spi_ack(spi_ack),
      .sen(sen), .sclk(sclk), .mosi(mosi), .miso(cat_miso),  // PLL has no miso
      .rb_data(rb_data), .rb_valid(rb_valid)
   );

   //////////////////////////////////////////////////
   // Board SPI pins
   //////////////////////////////////////////////////
   assign cat_ce   = sen[0];
   assign cat_mosi = ~sen[0] & mosi;
   assign cat_sclk = ~sen[0] & sclk;

   assign pll_ce   = sen[1];
   assign pll_mosi = ~sen[1] & mosi;
   assign pll_sclk = ~sen[1] & sclk;

endmodule

`default_nettype wire

// ==== sim/radio_ctrl_checker.sv ====
// Watches the SPI pins and readback port of the radio control slice
// Rebuilds frames per slave and compares values handed over by the testbench
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_checker (
   input  logic        bus_clk,
   input  logic        cat_ce,
   input  logic        cat_sclk,
   input  logic        cat_mosi,
   input  logic        pll_ce,
   input  logic        pll_sclk,
   input  logic        pll_mosi,
   input  logic [23:0] rb_data,
   input  logic        rb_valid,
   output logic [23:0] cat_frame,     // Bits seen in the last cat frame
   output int          cat_bits,
   output int          cat_frames,    // Completed cat frames
   output int          cat_active,    // Cycles with any cat pin off idle
   output logic [23:0] pll_frame,
   output int          pll_bits,
   output int          pll_frames,
   output int          pll_active,    // Cycles with any pll pin off idle
   output logic [23:0] rb_last,
   output int          rb_count
);

   int   err_count  = 0;
   int   test_count = 0;
   logic cat_ce_q   = 1'b1;   // Pin values one cycle back
   logic cat_sclk_q = 1'b0;
   logic pll_ce_q   = 1'b1;
   logic pll_sclk_q = 1'b0;

   initial begin
      cat_frame  = 24'h0;
      cat_bits   = 0;
      cat_frames = 0;
      cat_active = 0;
      pll_frame  = 24'h0;
      pll_bits   = 0;
      pll_frames = 0;
      pll_active = 0;
      rb_last    = 24'h0;
      rb_count   = 0;
   end

   //////////////////////////////////////////////////
   // Frame rebuild, mid-cycle where pins are settled
   //////////////////////////////////////////////////
   always @(negedge bus_clk) begin
      if (cat_ce_q && !cat_ce) begin
         cat_frame <= 24'h0;                          // New frame starts
         cat_bits  <= 0;
      end else if (!cat_ce && cat_sclk && !cat_sclk_q) begin
         cat_frame <= {cat_frame[22:0], cat_mosi};    // Slave samples on rise
         cat_bits  <= cat_bits + 1;
      end
      if (!cat_ce_q && cat_ce) cat_frames <= cat_frames + 1;
      if (!cat_ce || cat_sclk || cat_mosi) cat_active <= cat_active + 1;

      if (pll_ce_q && !pll_ce) begin
         pll_frame <= 24'h0;
         pll_bits  <= 0;
      end else if (!pll_ce && pll_sclk && !pll_sclk_q) begin
         pll_frame <= {pll_frame[22:0], pll_mosi};
         pll_bits  <= pll_bits + 1;
      end
      if (!pll_ce_q && pll_ce) pll_frames <= pll_frames + 1;
      if (!pll_ce || pll_sclk || pll_mosi) pll_active <= pll_active + 1;

      if (rb_valid) begin
         rb_last  <= rb_data;
         rb_count <= rb_count + 1;
      end

      cat_ce_q   <= cat_ce;
      cat_sclk_q <= cat_sclk;
      pll_ce_q   <= pll_ce;
      pll_sclk_q <= pll_sclk;
   end

   // One result line per comparison
   task automatic check_value(input string name, input logic [47:0] exp,
                              input logic [47:0] act);
      test_count++;
      if (exp !== act) begin
         err_count++;
         $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
      end else begin
         $display("[PASS] %s value %0h", name, act);
      end
   endtask

   task automatic report_counts(output bit all_ok);
      $display("tests %0d, passed %0d, failed %0d", test_count,
               test_count - err_count, err_count);
      all_ok = (err_count == 0) && (test_count > 0);
   endtask

endmodule

`default_nettype wire

// ==== sim/tb_radio_ctrl.sv ====
// Testbench for the radio control slice, runs a command table through the host port
// A cat slave model answers on miso, the checker module judges the pins
`timescale 1ns/1ps
`default_nettype none
`include "radio_ctrl_params.svh"

module tb_radio_ctrl;
   import radio_ctrl_pkg::*;

   localparam int N_TESTS = 10;
   localparam int TIMEOUT = 500;   // Cycles per wait
   localparam int K_ATR1  = 0;
   localparam int K_ATR2  = 1;
   localparam int K_MISC  = 2;
   localparam int K_NOCHG = 3;     // Unknown address
   localparam int K_CAT   = 4;
   localparam int K_PLL   = 5;
   localparam int K_DUMMY = 6;     // Slave code 2

   logic        bus_clk = 1'b0;
   logic        reset_global;
   logic        locked;
   logic        cmd_req;
   cmd_word_u   cmd_word;
   logic        cmd_ack;
   logic        cat_ce, cat_mosi, cat_sclk, cat_miso;
   logic        pll_ce, pll_mosi, pll_sclk;
   logic [7:0]  fe_atr1, fe_atr2, misc_outs;
   logic [23:0] rb_data;
   logic        rb_valid;

   // Checker views
   logic [23:0] cat_frame, pll_frame, rb_last;
   int          cat_bits, cat_frames, cat_active, pll_bits, pll_frames, pll_active, rb_count;

   // Stimulus table
   string       t_name [N_TESTS];
   logic [31:0] t_word [N_TESTS];
   int          t_kind [N_TESTS];
   logic [23:0] t_exp  [N_TESTS];
   logic [23:0] t_pat  [N_TESTS];   // cat miso pattern
   logic [23:0] t_rb   [N_TESTS];
   int          t_bits [N_TESTS];

   int          seed;
   logic [23:0] miso_pat = 24'h0;
   logic [4:0]  miso_idx = 5'd0;
   logic        m_ce_q   = 1'b1;
   logic        m_sclk_q = 1'b0;

   event        abort_ev;        // A wait ran out of time
   string       abort_msg;

   always #5 bus_clk = ~bus_clk;

   radio_ctrl_top radio_ctrl_top_i (
      .bus_clk(bus_clk), .reset_global(reset_global), .locked(locked),
      .cmd_req(cmd_req), .cmd_word(cmd_word), .cmd_ack(cmd_ack),
      .cat_ce(cat_ce), .cat_mosi(cat_mosi), .cat_sclk(cat_sclk), .cat_miso(cat_miso),
      .pll_ce(pll_ce), .pll_mosi(pll_mosi), .pll_sclk(pll_sclk),
      .fe_atr1(fe_atr1), .fe_atr2(fe_atr2), .misc_outs(misc_outs),
      .rb_data(rb_data), .rb_valid(rb_valid)
   );

   radio_ctrl_checker checker_i (
      .bus_clk(bus_clk), .cat_ce(cat_ce), .cat_sclk(cat_sclk), .cat_mosi(cat_mosi),
      .pll_ce(pll_ce), .pll_sclk(pll_sclk), .pll_mosi(pll_mosi),
      .rb_data(rb_data), .rb_valid(rb_valid),
      .cat_frame(cat_frame), .cat_bits(cat_bits), .cat_frames(cat_frames),
      .cat_active(cat_active),
      .pll_frame(pll_frame), .pll_bits(pll_bits), .pll_frames(pll_frames),
      .pll_active(pll_active), .rb_last(rb_last), .rb_count(rb_count)
   );

   //////////////////////////////////////////////////
   // Cat slave model, MSB first, next bit after each sclk fall
   //////////////////////////////////////////////////
   always @(posedge bus_clk) begin
      if (m_ce_q && !cat_ce) miso_idx <= 5'd0;
      else if (m_sclk_q && !cat_sclk) miso_idx <= miso_idx + 5'd1;
      m_ce_q   <= cat_ce;
      m_sclk_q <= cat_sclk;
   end
   assign cat_miso = (miso_idx <= 5'd23) ? miso_pat[5'd23 - miso_idx] : 1'b0;

   // Zero means 24, above 24 clipped
   function automatic int clip_len(input logic [4:0] len);
      if (len == 5'd0 || len > 5'd24) return 24;
      return int'(len);
   endfunction

   task automatic add_spi(input int i, input string name, input int kind,
                          input logic [1:0] slave, input logic [4:0] len);
      logic [23:0] d;
      int          n;
      d         = 24'($random(seed));
      n         = clip_len(len);
      t_name[i] = name;
      t_word[i] = {1'b1, slave, len, d};
      t_kind[i] = kind;
      t_pat[i]  = 24'($random(seed));
      t_exp[i]  = d >> (24 - n);               // Top n bits, as seen by the slave
      t_rb[i]   = t_pat[i] >> (24 - n);        // First n pattern bits
      t_bits[i] = n;
   endtask

   task automatic add_reg(input int i, input string name, input int kind,
                          input logic [6:0] addr);
      logic [23:0] d;
      d         = 24'($random(seed));
      t_name[i] = name;
      t_word[i] = {1'b0, addr, d};
      t_kind[i] = kind;
      t_exp[i]  = {16'h0, d[7:0]};
      t_pat[i]  = 24'h0;
      t_rb[i]   = 24'h0;
      t_bits[i] = 0;
   endtask

   task automatic build_table;
      add_reg(0, "atr1_write", K_ATR1, `RC_ADDR_ATR1);
      add_reg(1, "atr2_write", K_ATR2, `RC_ADDR_ATR2);
      add_reg(2, "misc_write", K_MISC, `RC_ADDR_MISC);
      add_reg(3, "unknown_addr", K_NOCHG, 7'd9);
      t_exp[3] = {t_exp[0][7:0], t_exp[1][7:0], t_exp[2][7:0]};   // Nothing moves
      add_spi(4, "cat_len8", K_CAT, 2'd0, 5'd8);
      add_spi(5, "cat_len0", K_CAT, 2'd0, 5'd0);
      add_spi(6, "cat_len13", K_CAT, 2'd0, 5'd13);
      add_spi(7, "cat_len30", K_CAT, 2'd0, 5'd30);
      add_spi(8, "pll_len24", K_PLL, 2'd1, 5'd24);
      add_spi(9, "dummy_slave2", K_DUMMY, 2'd2, 5'd5);
   endtask

   // Hands the message to the abort process and parks the caller
   task automatic abort_run(input string msg);
      abort_msg = msg;
      -> abort_ev;
      forever @(posedge bus_clk);
   endtask

   initial begin
      @(abort_ev);
      $display("%s", abort_msg);
      $display("Test FAILED");
      $finish;
   end

   task automatic wait_ack(input logic level, output int cycles);
      cycles = 0;
      while (cmd_ack !== level) begin
         @(posedge bus_clk);
         #1;
         cycles++;
         if (cycles > TIMEOUT) abort_run("no cmd_ack change from DUT within timeout");
      end
   endtask

   task automatic wait_rb(input int target);
      int n;
      n = 0;
      while (rb_count < target) begin
         @(posedge bus_clk);
         #1;
         n++;
         if (n > TIMEOUT) abort_run("no rb_valid from DUT within timeout");
      end
   endtask

   function automatic logic [23:0] reg_value(input int kind);
      case (kind)
         K_ATR1:  return {16'h0, fe_atr1};
         K_ATR2:  return {16'h0, fe_atr2};
         K_MISC:  return {16'h0, misc_outs};
         default: return {fe_atr1, fe_atr2, misc_outs};
      endcase
   endfunction

   task automatic send_cmd(input logic [31:0] word);
      int cyc;
      @(posedge bus_clk);
      #1;
      cmd_word = word;
      cmd_req  = 1'b1;
      wait_ack(1'b1, cyc);
      cmd_req = 1'b0;
      wait_ack(1'b0, cyc);
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////
   initial begin
      int          cyc;
      int          rb0, cf0, pf0, ca0, pa0, n;
      bit          all_ok;
      logic [23:0] d1, d2, d3;
      reset_global = 1'b1;
      locked       = 1'b0;
      cmd_req      = 1'b0;
      cmd_word     = 32'h0;
      seed         = 32'h6ac1;
      build_table();

      repeat (10) @(posedge bus_clk);
      #1 reset_global = 1'b0;
      @(posedge bus_clk);
      #1 locked = 1'b1;

      for (int i = 0; i < N_TESTS; i++) begin
         miso_pat = t_pat[i];
         rb0 = rb_count;
         cf0 = cat_frames;
         pf0 = pll_frames;
         ca0 = cat_active;
         pa0 = pll_active;
         @(posedge bus_clk);
         #1;
         cmd_word = t_word[i];
         cmd_req  = 1'b1;
         wait_ack(1'b1, cyc);
         if (i == 0) begin
            // First request went up right after lock
            checker_i.check_value("holdoff", 48'd1, 48'(cyc >= 2**`RC_HOLDOFF_BITS));
            checker_i.check_value("reset_regs", 48'd0,
               48'({fe_atr1, fe_atr2, misc_outs, rb_data}));
            checker_i.check_value("reset_spi", 48'b1100000,
               48'({cat_ce, pll_ce, cat_sclk, pll_sclk, cat_mosi, pll_mosi, rb_valid}));
         end
         cmd_req = 1'b0;
         wait_ack(1'b0, cyc);

         case (t_kind[i])
            K_CAT: begin
               wait_rb(rb0 + 1);
               checker_i.check_value({t_name[i], " frame"},
                                     48'({8'd1, 8'(t_bits[i]), t_exp[i]}),
                                     48'({8'(cat_frames - cf0), 8'(cat_bits), cat_frame}));
               checker_i.check_value({t_name[i], " readback"}, 48'(t_rb[i]), 48'(rb_last));
               checker_i.check_value({t_name[i], " pll_idle"}, 48'd0,
                                     48'(pll_active - pa0));
            end
            K_PLL: begin
               wait_rb(rb0 + 1);
               checker_i.check_value({t_name[i], " frame"},
                                     48'({8'd1, 8'(t_bits[i]), t_exp[i]}),
                                     48'({8'(pll_frames - pf0), 8'(pll_bits), pll_frame}));
               checker_i.check_value({t_name[i], " cat_idle"}, 48'd0,
                                     48'(cat_active - ca0));
            end
            K_DUMMY: begin
               wait_rb(rb0 + 1);
               checker_i.check_value({t_name[i], " no_select"}, 48'd0,
                                     48'((cat_active - ca0) + (pll_active - pa0)));
            end
            default: begin
               if (t_kind[i] == K_NOCHG) begin
                  repeat (10) @(posedge bus_clk);
                  #1;
               end
               n = 0;
               while (reg_value(t_kind[i]) !== t_exp[i] && n < 20) begin
                  @(posedge bus_clk);
                  #1;
                  n++;
               end
               checker_i.check_value(t_name[i], 48'(t_exp[i]), 48'(reg_value(t_kind[i])));
            end
         endcase
      end

      // Back to back: cat job, register write, pll job
      miso_pat = 24'($random(seed));
      d1  = 24'($random(seed));
      d2  = 24'($random(seed));
      d3  = 24'($random(seed));
      rb0 = rb_count;
      send_cmd({1'b1, 2'd0, 5'd16, d1});
      send_cmd({1'b0, `RC_ADDR_ATR2, d2});
      send_cmd({1'b1, 2'd1, 5'd20, d3});
      wait_rb(rb0 + 2);
      checker_i.check_value("b2b cat frame", 48'({8'd16, d1 >> 8}),
                            48'({8'(cat_bits), cat_frame}));
      checker_i.check_value("b2b pll frame", 48'({8'd20, d3 >> 4}),
                            48'({8'(pll_bits), pll_frame}));
      checker_i.check_value("b2b atr2", 48'(d2[7:0]), 48'(fe_atr2));

      checker_i.report_counts(all_ok);
      if (all_ok) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
src/radio_ctrl_pkg.sv
src/clocks_ready_hold.sv
src/cmd_intake.sv
src/settings_decode.sv
src/spi_engine.sv
src/radio_ctrl_top.sv
sim/radio_ctrl_checker.sv
sim/tb_radio_ctrl.sv

// ==== Makefile ====
# Verilator build and run for the radio control slice

VERILATOR ?= verilator
TOP       ?= tb_radio_ctrl
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test OK

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
